// ==== hw/int_exec_pkg.sv ====
package int_exec_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xword_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [11:0]     imm_i_t;   // Instruction bits 31:20
    typedef logic [19:0]     imm_u_t;   // Instruction bits 31:12

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        LUI       = 5'b01101,
        AUIPC     = 5'b00101,
        OP_IMM    = 5'b00100,
        OP_IMM_32 = 5'b00110,
        OP        = 5'b01100,
        OP_32     = 5'b01110
    } opcode_e;

    localparam funct7_t FUNCT7_BASE   = 7'b0000000;
    localparam funct7_t FUNCT7_ALT    = 7'b0100000;  // SUB and SRA
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

    localparam funct3_t F3_ADD    = 3'b000;
    localparam funct3_t F3_SLL    = 3'b001;
    localparam funct3_t F3_SLT    = 3'b010;
    localparam funct3_t F3_SLTU   = 3'b011;
    localparam funct3_t F3_XOR    = 3'b100;
    localparam funct3_t F3_SRL    = 3'b101;  // SRL and SRA
    localparam funct3_t F3_OR     = 3'b110;
    localparam funct3_t F3_AND    = 3'b111;

    localparam funct3_t F3_MUL    = 3'b000;
    localparam funct3_t F3_MULH   = 3'b001;
    localparam funct3_t F3_MULHSU = 3'b010;
    localparam funct3_t F3_MULHU  = 3'b011;

    typedef struct packed {
        opcode_e opcode;
        funct3_t funct3;
        funct7_t funct7;
        xword_t  rs1_data;
        xword_t  rs2_data;
        imm_i_t  imm_i;
        imm_u_t  imm_u;
        xword_t  inst_addr;
    } exec_req_t;

    typedef struct packed {
        logic   exception;
        xword_t result;
    } exec_res_t;

endpackage

// ==== hw/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
    input  logic                    i_valid,
    input  int_exec_pkg::exec_req_t i_req,
    output logic                    o_valid,
    output int_exec_pkg::exec_res_t o_res
);
    import int_exec_pkg::*;

    xword_t      imm_i_sx;
    xword_t      imm_u_sx;
    xword_t      opnd_b;
    logic        is_reg;
    logic        alt;
    logic [5:0]  shamt;
    logic [31:0] a_w;
    logic [31:0] b_w;
    xword_t      srl_x;
    xword_t      sra_x;
    logic [31:0] srl_w;
    logic [31:0] sra_w;
    xword_t      res_x;
    logic [31:0] res_w;
    logic        w_funct3_ok;
    logic        illegal;
    xword_t      result;

    assign imm_i_sx = {{(XLEN-12){i_req.imm_i[11]}}, i_req.imm_i};
    assign imm_u_sx = {{(XLEN-32){i_req.imm_u[19]}}, i_req.imm_u, 12'b0};

    // Register forms take rs2, immediate forms take the I-immediate
    assign is_reg = (i_req.opcode == OP) || (i_req.opcode == OP_32);
    assign opnd_b = is_reg ? i_req.rs2_data : imm_i_sx;
    assign alt    = is_reg ? i_req.funct7[5] : i_req.imm_i[10];
    assign shamt  = opnd_b[5:0];

    assign a_w = i_req.rs1_data[31:0];
    assign b_w = opnd_b[31:0];

    assign srl_x = i_req.rs1_data >> shamt;
    assign sra_x = $signed(i_req.rs1_data) >>> shamt;
    assign srl_w = a_w >> shamt[4:0];             // Zeros in, even for a negative word
    assign sra_w = $signed(a_w) >>> shamt[4:0];

    always_comb begin
        case (i_req.funct3)
            F3_ADD:  res_x = (is_reg && alt) ? i_req.rs1_data - opnd_b : i_req.rs1_data + opnd_b;
            F3_SLL:  res_x = i_req.rs1_data << shamt;
            F3_SLT:  res_x = xword_t'($signed(i_req.rs1_data) < $signed(opnd_b));
            F3_SLTU: res_x = xword_t'(i_req.rs1_data < opnd_b);
            F3_XOR:  res_x = i_req.rs1_data ^ opnd_b;
            F3_SRL:  res_x = alt ? sra_x : srl_x;
            F3_OR:   res_x = i_req.rs1_data | opnd_b;
            F3_AND:  res_x = i_req.rs1_data & opnd_b;
        endcase
    end

    always_comb begin
        case (i_req.funct3)
            F3_ADD:  res_w = (is_reg && alt) ? a_w - b_w : a_w + b_w;
            F3_SLL:  res_w = a_w << shamt[4:0];
            F3_SRL:  res_w = alt ? sra_w : srl_w;
            default: res_w = '0;
        endcase
    end

    assign w_funct3_ok = (i_req.funct3 == F3_ADD) || (i_req.funct3 == F3_SLL)
                      || (i_req.funct3 == F3_SRL);

    always_comb begin
        illegal = 1'b0;
        case (i_req.opcode)
            LUI, AUIPC: begin
                illegal = 1'b0;
            end
            OP, OP_32: begin
                if (i_req.funct7 != FUNCT7_BASE && i_req.funct7 != FUNCT7_ALT) begin
                    illegal = 1'b1;
                end else if (alt && i_req.funct3 != F3_ADD && i_req.funct3 != F3_SRL) begin
                    illegal = 1'b1;                         // Only SUB and SRA use bit 5
                end
                if (i_req.opcode == OP_32 && !w_funct3_ok) begin
                    illegal = 1'b1;
                end
            end
            OP_IMM: begin
                if (i_req.funct3 == F3_SLL) begin
                    illegal = |i_req.imm_i[11:6];
                end else if (i_req.funct3 == F3_SRL) begin
                    illegal = i_req.imm_i[11] | (|i_req.imm_i[9:6]);
                end
            end
            OP_IMM_32: begin
                if (!w_funct3_ok) begin
                    illegal = 1'b1;
                end else if (i_req.funct3 == F3_SLL) begin
                    illegal = |i_req.imm_i[11:5];           // shamt[5] set is illegal too
                end else if (i_req.funct3 == F3_SRL) begin
                    illegal = i_req.imm_i[11] | (|i_req.imm_i[9:5]);
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (i_req.opcode)
            LUI:              result = imm_u_sx;
            AUIPC:            result = i_req.inst_addr + imm_u_sx;
            OP_IMM_32, OP_32: result = {{(XLEN-32){res_w[31]}}, res_w};
            default:          result = res_x;
        endcase
    end

    assign o_valid         = i_valid;
    assign o_res.exception = illegal;
    assign o_res.result    = illegal ? '0 : result;

endmodule

// ==== hw/int_mul.sv ====
`timescale 1ns/100ps

module int_mul (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  int_exec_pkg::exec_req_t i_req,
    output logic                    o_valid,
    output int_exec_pkg::exec_res_t o_res
);
    import int_exec_pkg::*;

    logic                rs1_signed;
    logic                rs2_signed;
    xword_t              pp_hh;
    xword_t              pp_hl;
    xword_t              pp_lh;
    xword_t              pp_ll;
    xword_t              corr;
    opcode_e             opcode_q;
    funct3_t             funct3_q;
    logic                valid_q;
    logic [2*XLEN-1:0]   low_sum;
    logic [2*XLEN-1:0]   product;
    logic                exc;
    xword_t              result;

    assign rs1_signed = (i_req.funct3 == F3_MULH) || (i_req.funct3 == F3_MULHSU);
    assign rs2_signed = (i_req.funct3 == F3_MULH);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            pp_hh    <= xword_t'(i_req.rs1_data[63:32]) * xword_t'(i_req.rs2_data[63:32]);
            pp_hl    <= xword_t'(i_req.rs1_data[63:32]) * xword_t'(i_req.rs2_data[31:0]);
            pp_lh    <= xword_t'(i_req.rs1_data[31:0]) * xword_t'(i_req.rs2_data[63:32]);
            pp_ll    <= xword_t'(i_req.rs1_data[31:0]) * xword_t'(i_req.rs2_data[31:0]);
            // Negative operand weighs -2^64, folded into the high half
            corr     <= ((rs1_signed && i_req.rs1_data[XLEN-1]) ? -i_req.rs2_data : '0)
                      + ((rs2_signed && i_req.rs2_data[XLEN-1]) ? -i_req.rs1_data : '0);
            opcode_q <= i_req.opcode;
            funct3_q <= i_req.funct3;
        end
    end

    assign low_sum = {64'b0, pp_ll} + {32'b0, pp_hl, 32'b0} + {32'b0, pp_lh, 32'b0};
    assign product = {pp_hh + corr, 64'b0} + low_sum;

    always_comb begin
        exc    = 1'b0;
        result = '0;
        if (opcode_q == OP_32) begin
            if (funct3_q == F3_MUL) begin
                result = {{(XLEN-32){product[31]}}, product[31:0]};  // MULW
            end else begin
                exc = 1'b1;
            end
        end else begin
            case (funct3_q)
                F3_MUL:                        result = product[XLEN-1:0];
                F3_MULH, F3_MULHSU, F3_MULHU:  result = product[2*XLEN-1:XLEN];
                default:                       exc = 1'b1;  // No divider here
            endcase
        end
    end

    assign o_valid         = valid_q;
    assign o_res.exception = exc;
    assign o_res.result    = result;

endmodule

// ==== hw/result_arbiter.sv ====
`timescale 1ns/100ps

module result_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_alu_valid,
    input  logic                    i_mul_valid,
    input  int_exec_pkg::exec_res_t i_alu_res,
    input  int_exec_pkg::exec_res_t i_mul_res,
    output logic                    o_valid,
    output int_exec_pkg::exec_res_t o_res
);

    logic grant_mul;
    logic grant_alu;

    // Multiplier is older, so it always wins a collision
    assign grant_mul = i_mul_valid;
    assign grant_alu = i_alu_valid && !i_mul_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= grant_mul || grant_alu;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_mul) begin
            o_res <= i_mul_res;
        end else if (grant_alu) begin
            o_res <= i_alu_res;
        end
    end

endmodule

// ==== hw/int_exec_top.sv ====
`timescale 1ns/100ps

module int_exec_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  int_exec_pkg::exec_req_t i_req,
    output logic                    o_valid,
    output int_exec_pkg::exec_res_t o_res
);
    import int_exec_pkg::*;

    logic      is_mul;
    logic      alu_req_valid;
    logic      mul_req_valid;
    logic      alu_valid;
    logic      mul_valid;
    exec_res_t alu_res;
    exec_res_t mul_res;

    // M-extension encodings go to the multiplier, everything else to the ALU
    assign is_mul = ((i_req.opcode == OP) || (i_req.opcode == OP_32))
                 && (i_req.funct7 == FUNCT7_MULDIV);

    assign alu_req_valid = i_valid && !is_mul;
    assign mul_req_valid = i_valid && is_mul;

    int_alu u_alu (
        .i_valid (alu_req_valid),
        .i_req   (i_req),
        .o_valid (alu_valid),
        .o_res   (alu_res)
    );

    int_mul u_mul (
        .clk     (clk),
        .rst     (rst),
        .i_valid (mul_req_valid),
        .i_req   (i_req),
        .o_valid (mul_valid),
        .o_res   (mul_res)
    );

    result_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .i_alu_valid (alu_valid),
        .i_mul_valid (mul_valid),
        .i_alu_res   (alu_res),
        .i_mul_res   (mul_res),
        .o_valid     (o_valid),
        .o_res       (o_res)
    );

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;    // 20 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// ==== dv/int_exec_assert.sv ====
`timescale 1ns/100ps

module int_exec_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    i_valid,
    input int_exec_pkg::exec_req_t i_req,
    input logic                    i_alu_valid,
    input logic                    i_mul_valid
);
    import int_exec_pkg::*;

    logic is_mul;
    int   fail_count = 0;

    assign is_mul = ((i_req.opcode == OP) || (i_req.opcode == OP_32))
                 && (i_req.funct7 == FUNCT7_MULDIV);

    // ALU result of the next cycle would meet the multiply result at the arbiter
    issue_rule: assert property (@(posedge clk) disable iff (rst)
        (i_valid && is_mul) |=> !(i_valid && !is_mul))
        else begin
            $error("ALU request issued in the cycle right after a multiply");
            fail_count++;
        end

    peer_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_alu_valid && i_mul_valid))
        else begin
            $error("ALU and multiplier results valid in the same cycle");
            fail_count++;
        end

endmodule

// ==== dv/int_exec_tb.sv ====
`timescale 1ns/100ps

module int_exec_tb;
    import int_exec_pkg::*;

    localparam int MAX_ROWS = 80;

    typedef struct packed {
        int        row;
        int        due;     // Cycle count at which o_valid is expected
        exec_res_t exp;
    } pend_t;

    logic      clk;
    logic      rst;
    logic      i_valid;
    exec_req_t i_req;
    logic      o_valid;
    exec_res_t o_res;

    exec_req_t tbl_req [MAX_ROWS];
    exec_res_t tbl_exp [MAX_ROWS];
    string     tbl_name [MAX_ROWS];
    int        n_rows = 0;
    pend_t     pending [$];
    int        seed = 32'h73be_c9e4;
    int        cycle = 0;
    int        cycle_limit = MAX_ROWS * 3 + 20;
    int        errors = 0;
    int        rows_pass = 0;
    int        rows_fail = 0;
    logic      prev_mul;

    tb_clkgen u_clkgen (.o_clk(clk), .o_rst(rst));

    int_exec_top UUT (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_req   (i_req),
        .o_valid (o_valid),
        .o_res   (o_res)
    );

    bind int_exec_top int_exec_assert u_assert (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .i_req       (i_req),
        .i_alu_valid (alu_valid),
        .i_mul_valid (mul_valid)
    );

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic xword_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic is_mul_req(input exec_req_t r);
        return ((r.opcode == OP) || (r.opcode == OP_32)) && (r.funct7 == FUNCT7_MULDIV);
    endfunction

    // Behavioral model of one request
    function automatic exec_res_t ref_model(input exec_req_t r);
        exec_res_t    out;
        xword_t       a;
        xword_t       b;
        xword_t       res;
        logic [31:0]  a32;
        logic [31:0]  b32;
        logic [31:0]  w;
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] p;
        logic         reg_form;
        logic         alt;
        logic         ill;
        reg_form = (r.opcode == OP) || (r.opcode == OP_32);
        a   = r.rs1_data;
        b   = reg_form ? r.rs2_data : {{52{r.imm_i[11]}}, r.imm_i};
        alt = reg_form ? r.funct7[5] : r.imm_i[10];
        a32 = a[31:0];
        b32 = b[31:0];
        res = '0;
        w   = '0;
        ill = 1'b0;
        if (is_mul_req(r)) begin
            ea = {{64{a[63] && (r.funct3 == F3_MULH || r.funct3 == F3_MULHSU)}}, a};
            eb = {{64{b[63] && (r.funct3 == F3_MULH)}}, b};
            p  = ea * eb;           // Exact product modulo 2^128
            if (r.opcode == OP_32) begin
                ill = (r.funct3 != F3_MUL);
                res = {{32{p[31]}}, p[31:0]};
            end else if (r.funct3 == F3_MUL) begin
                res = p[63:0];
            end else if (r.funct3 inside {F3_MULH, F3_MULHSU, F3_MULHU}) begin
                res = p[127:64];
            end else begin
                ill = 1'b1;         // Divide not implemented
            end
        end else begin
            case (r.opcode)
                LUI:   res = {{32{r.imm_u[19]}}, r.imm_u, 12'h000};
                AUIPC: res = r.inst_addr + {{32{r.imm_u[19]}}, r.imm_u, 12'h000};
                OP, OP_IMM: begin
                    if (r.opcode == OP) begin
                        ill = !(r.funct7 == FUNCT7_BASE || (r.funct7 == FUNCT7_ALT
                              && (r.funct3 == F3_ADD || r.funct3 == F3_SRL)));
                    end else if (r.funct3 == F3_SLL) begin
                        ill = (r.imm_i[11:6] != 6'b000000);
                    end else if (r.funct3 == F3_SRL) begin
                        ill = !(r.imm_i[11:6] == 6'b000000 || r.imm_i[11:6] == 6'b010000);
                    end
                    case (r.funct3)
                        F3_ADD:  res = (r.opcode == OP && alt) ? a - b : a + b;
                        F3_SLL:  res = a << b[5:0];
                        F3_SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        F3_SLTU: res = (a < b) ? 64'd1 : 64'd0;
                        F3_XOR:  res = a ^ b;
                        F3_SRL: begin
                            if (alt) begin
                                res = $signed(a) >>> b[5:0];
                            end else begin
                                res = a >> b[5:0];
                            end
                        end
                        F3_OR:   res = a | b;
                        F3_AND:  res = a & b;
                    endcase
                end
                OP_32, OP_IMM_32: begin
                    if (!(r.funct3 inside {F3_ADD, F3_SLL, F3_SRL})) begin
                        ill = 1'b1;
                    end else if (r.opcode == OP_32) begin
                        ill = !(r.funct7 == FUNCT7_BASE
                              || (r.funct7 == FUNCT7_ALT && r.funct3 != F3_SLL));
                    end else if (r.funct3 == F3_SLL) begin
                        ill = (r.imm_i[11:5] != 7'b0000000);
                    end else if (r.funct3 == F3_SRL) begin
                        ill = !(r.imm_i[11:5] == 7'b0000000 || r.imm_i[11:5] == 7'b0100000);
                    end
                    if (r.funct3 == F3_ADD) begin
                        w = (r.opcode == OP_32 && alt) ? a32 - b32 : a32 + b32;
                    end else if (r.funct3 == F3_SLL) begin
                        w = a32 << b32[4:0];
                    end else if (alt) begin
                        w = $signed(a32) >>> b32[4:0];
                    end else begin
                        w = a32 >> b32[4:0];
                    end
                    res = {{32{w[31]}}, w};
                end
                default: ill = 1'b1;
            endcase
        end
        out.exception = ill;
        out.result    = ill ? '0 : res;
        return out;
    endfunction

    task automatic add_row(input string name, input opcode_e op, input funct3_t f3,
                           input funct7_t f7, input xword_t a, input xword_t b,
                           input imm_i_t ii, input imm_u_t iu, input xword_t pc);
        exec_req_t r;
        if (n_rows >= MAX_ROWS) begin
            $display("Error: stimulus table is full, row %s dropped", name);
            errors++;
            return;
        end
        r.opcode    = op;
        r.funct3    = f3;
        r.funct7    = f7;
        r.rs1_data  = a;
        r.rs2_data  = b;
        r.imm_i     = ii;
        r.imm_u     = iu;
        r.inst_addr = pc;
        tbl_req[n_rows]  = r;
        tbl_exp[n_rows]  = ref_model(r);
        tbl_name[n_rows] = name;
        n_rows++;
    endtask

    task automatic add_r(input string name, input opcode_e op, input funct3_t f3,
                         input funct7_t f7, input xword_t a, input xword_t b);
        add_row(name, op, f3, f7, a, b, '0, '0, '0);
    endtask

    task automatic add_i(input string name, input opcode_e op, input funct3_t f3,
                         input imm_i_t imm, input xword_t a);
        add_row(name, op, f3, FUNCT7_BASE, a, '0, imm, '0, '0);
    endtask

    task automatic add_u(input string name, input opcode_e op, input imm_u_t imm,
                         input xword_t pc);
        add_row(name, op, F3_ADD, FUNCT7_BASE, '0, '0, '0, imm, pc);
    endtask

    task automatic build_table();
        xword_t      mn;
        xword_t      m1;
        logic [31:0] pick;
        mn = 64'h8000_0000_0000_0000;
        m1 = '1;
        add_r("add", OP, F3_ADD, FUNCT7_BASE, rand_word(), rand_word());
        add_r("sub", OP, F3_ADD, FUNCT7_ALT, rand_word(), rand_word());
        add_r("sub wrap", OP, F3_ADD, FUNCT7_ALT, 64'd0, 64'd1);
        add_r("sll", OP, F3_SLL, FUNCT7_BASE, rand_word(), rand_word());
        add_r("srl", OP, F3_SRL, FUNCT7_BASE, mn | 64'd1, 64'd4);
        add_r("sra", OP, F3_SRL, FUNCT7_ALT, mn | 64'd1, 64'd4);
        add_r("slt", OP, F3_SLT, FUNCT7_BASE, 64'hFFFF_FFFF_FFFF_FFFB, 64'd3);
        add_r("sltu", OP, F3_SLTU, FUNCT7_BASE, 64'hFFFF_FFFF_FFFF_FFFB, 64'd3);
        add_r("xor", OP, F3_XOR, FUNCT7_BASE, rand_word(), rand_word());
        add_r("or", OP, F3_OR, FUNCT7_BASE, rand_word(), rand_word());
        add_r("and", OP, F3_AND, FUNCT7_BASE, rand_word(), rand_word());
        add_i("addi -1", OP_IMM, F3_ADD, 12'hFFF, rand_word());
        add_i("addi min", OP_IMM, F3_ADD, 12'h800, 64'd0);
        add_i("slti", OP_IMM, F3_SLT, 12'hF00, 64'hFFFF_FFFF_FFFF_FE00);
        add_i("sltiu", OP_IMM, F3_SLTU, 12'hFFF, 64'd5);
        add_i("xori", OP_IMM, F3_XOR, 12'hFFF, rand_word());
        add_i("ori", OP_IMM, F3_OR, 12'h8A5, rand_word());
        add_i("andi", OP_IMM, F3_AND, 12'hF0F, rand_word());
        add_i("slli 63", OP_IMM, F3_SLL, 12'h03F, rand_word());
        add_i("srli 33", OP_IMM, F3_SRL, 12'h021, m1);
        add_i("srai 33", OP_IMM, F3_SRL, 12'h421, 64'hF000_0000_0000_0000);
        add_u("lui neg", LUI, 20'h80000, '0);
        add_u("lui pos", LUI, 20'h12345, '0);
        add_u("auipc neg", AUIPC, 20'hFFFFF, 64'h0000_0000_8000_0000);
        add_u("auipc pos", AUIPC, 20'h7FFFF, rand_word());
        add_r("addw ovf", OP_32, F3_ADD, FUNCT7_BASE, 64'h0000_0000_7FFF_FFFF, 64'd1);
        add_r("subw", OP_32, F3_ADD, FUNCT7_ALT, rand_word(), rand_word());
        add_r("sllw", OP_32, F3_SLL, FUNCT7_BASE, rand_word(), 64'd31);
        add_r("srlw 0", OP_32, F3_SRL, FUNCT7_BASE, 64'h1234_5678_8765_4321, 64'd0);
        add_r("srlw 1", OP_32, F3_SRL, FUNCT7_BASE, 64'hFFFF_FFFF_8000_0000, 64'd1);
        add_r("sraw", OP_32, F3_SRL, FUNCT7_ALT, 64'h0000_0000_8000_0000, 64'd4);
        add_i("addiw", OP_IMM_32, F3_ADD, 12'hFFF, 64'h0000_0000_8000_0000);
        add_i("slliw", OP_IMM_32, F3_SLL, 12'h01F, 64'd1);
        add_i("srliw 0", OP_IMM_32, F3_SRL, 12'h000, 64'h0000_0000_F000_000F);
        add_i("sraiw", OP_IMM_32, F3_SRL, 12'h410, 64'h0000_0000_8000_0000);
        add_r("mul", OP, F3_MUL, FUNCT7_MULDIV, rand_word(), rand_word());
        add_r("mulh", OP, F3_MULH, FUNCT7_MULDIV, rand_word(), rand_word());
        add_r("mulhsu", OP, F3_MULHSU, FUNCT7_MULDIV, rand_word(), rand_word());
        add_r("mulhu", OP, F3_MULHU, FUNCT7_MULDIV, rand_word(), rand_word());
        add_r("mulw", OP_32, F3_MUL, FUNCT7_MULDIV, rand_word(), rand_word());
        add_r("mulh min*min", OP, F3_MULH, FUNCT7_MULDIV, mn, mn);
        add_r("mulh min*-1", OP, F3_MULH, FUNCT7_MULDIV, mn, m1);
        add_r("mulhsu -1*max", OP, F3_MULHSU, FUNCT7_MULDIV, m1, m1);
        add_r("mulhu max*max", OP, F3_MULHU, FUNCT7_MULDIV, m1, m1);
        add_r("mul min*-1", OP, F3_MUL, FUNCT7_MULDIV, mn, m1);
        add_r("mul zero", OP, F3_MUL, FUNCT7_MULDIV, 64'd0, rand_word());
        add_r("mulw ovf", OP_32, F3_MUL, FUNCT7_MULDIV, 64'h0000_0000_7FFF_FFFF, 64'd2);
        add_r("sll alt bad", OP, F3_SLL, FUNCT7_ALT, rand_word(), rand_word());
        add_r("xor f7 bad", OP, F3_XOR, 7'b0000010, rand_word(), rand_word());
        add_i("imm32 f3 010", OP_IMM_32, F3_SLT, 12'h000, rand_word());
        add_i("slli shamt bad", OP_IMM, F3_SLL, 12'h040, rand_word());
        add_i("slliw shamt bad", OP_IMM_32, F3_SLL, 12'h020, rand_word());
        add_r("opcode bad", opcode_e'(5'b11111), F3_ADD, FUNCT7_BASE, rand_word(), '0);
        add_r("mulw f3 001", OP_32, F3_MULH, FUNCT7_MULDIV, rand_word(), rand_word());
        add_r("div dropped", OP, 3'b100, FUNCT7_MULDIV, rand_word(), rand_word());
        for (int k = 0; k < 10; k++) begin
            pick = $random(seed);
            if (pick[0]) begin
                add_r("mixed mul", OP, {1'b0, pick[2:1]}, FUNCT7_MULDIV,
                      rand_word(), rand_word());
            end else begin
                add_r("mixed alu", OP, pick[3:1], FUNCT7_BASE, rand_word(), rand_word());
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_row(input int row, input logic ok);
        $display("row %0d %s: %s", row, tbl_name[row], ok ? "ok" : "FAIL");
        if (ok) begin
            rows_pass++;
        end else begin
            rows_fail++;
        end
    endtask

    // Outputs settle after the rising edge, so they are read at the falling edge
    task automatic check_outputs();
        pend_t p;
        int    err_before;
        if (o_valid) begin
            if (pending.size() == 0) begin
                $display("Error at %0t: o_valid high with no request outstanding", $time);
                errors++;
            end else begin
                p = pending.pop_front();
                err_before = errors;
                check_value("o_valid cycle", 64'(cycle), 64'(p.due));
                check_value("o_res.exception", 64'(o_res.exception), 64'(p.exp.exception));
                check_value("o_res.result", o_res.result, p.exp.result);
                report_row(p.row, errors == err_before);
            end
        end else if (pending.size() != 0 && pending[0].due <= cycle) begin
            p = pending.pop_front();
            $display("Error at %0t: no result for row %0d by cycle %0d", $time, p.row, p.due);
            errors++;
            report_row(p.row, 1'b0);
        end
    endtask

    task automatic step(input logic v, input int row);
        pend_t p;
        @(negedge clk);
        check_outputs();
        i_valid = v;
        if (v) begin
            i_req = tbl_req[row];
            p.row = row;
            p.due = cycle + (is_mul_req(tbl_req[row]) ? 2 : 1);
            p.exp = tbl_exp[row];
            pending.push_back(p);
        end
    endtask

    initial begin
        i_valid = 1'b0;
        i_req   = '0;
        build_table();
        cycle_limit = n_rows * 3 + 20;
        @(negedge rst);
        repeat (3) begin
            step(1'b0, 0);
            check_value("o_valid", 64'(o_valid), 64'd0);   // Low before the first issue
        end
        prev_mul = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            if (prev_mul && !is_mul_req(tbl_req[i])) begin
                step(1'b0, 0);
            end
            step(1'b1, i);
            prev_mul = is_mul_req(tbl_req[i]);
        end
        step(1'b0, 0);
        while (pending.size() != 0) begin
            step(1'b0, 0);
        end
        repeat (2) step(1'b0, 0);
        if (UUT.u_assert.fail_count != 0) begin
            $display("Error: %0d assertion failures reported", UUT.u_assert.fail_count);
            errors += UUT.u_assert.fail_count;
        end
        $display("Summary: %0d requests, %0d passed, %0d failed, %0d errors",
                 n_rows, rows_pass, rows_fail, errors);
        if (errors == 0 && rows_pass == n_rows) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/int_exec_pkg.sv
hw/int_alu.sv
hw/int_mul.sv
hw/result_arbiter.sv
hw/int_exec_top.sv
dv/tb_clkgen.sv
dv/int_exec_assert.sv
dv/int_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= int_exec_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
